//--- compile.f
design/memPkg.sv
design/cacheControl.sv
design/instrCache.sv
design/dataCache.sv
design/busArbiter.sv
design/busMemory.sv
design/memSubsystem.sv
verif/memChecker.sv
verif/memSubsystemTb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing
TOP       := memSubsystemTb
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verif/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
  import memPkg::*;

  // A refill word may wait behind one transfer of the other cache
  localparam int WorstStall = 2 * BlockWords * (MemLatency + 2);
  localparam int NumOps = 600;
  localparam int TimeoutCycles = 2 * NumOps * WorstStall;
  // Known-value window in words
  localparam int WindowWords = 256;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 fetchReq;
  logic [AddrWidth-1:0] fetchAddr;
  logic [DataWidth-1:0] instr;
  logic                 instrStall;
  logic                 memRead;
  logic                 memWrite;
  logic [AddrWidth-1:0] dataAddr;
  logic [DataWidth-1:0] writeData;
  logic [3:0]           byteMask;
  logic [DataWidth-1:0] readData;
  logic                 dataStall;
  logic                 cfgWrite;
  logic [2:0]           cfgData;

  // Stall expectations handed to the checker
  logic       fetchMustStall;
  logic       fetchMustHit;
  logic       dataMustStall;
  logic       dataMustHit;
  logic [2:0] phase;

  int readErrors;
  int fetchErrors;
  int stallErrors;
  int checkCount;
  int cycleCount;
  integer seed;

  // Addresses stored in the write phase, fetched again later
  logic [AddrWidth-1:0] written [$];
  // Lines touched since the last invalidate
  logic [NumLines-1:0]  iTouched;
  logic [NumLines-1:0]  dTouched;

  memSubsystem DUT (
    .clk(clk), .reset(reset),
    .fetchReq(fetchReq), .fetchAddr(fetchAddr), .instr(instr), .instrStall(instrStall),
    .memRead(memRead), .memWrite(memWrite), .dataAddr(dataAddr), .writeData(writeData),
    .byteMask(byteMask), .readData(readData), .dataStall(dataStall),
    .cfgWrite(cfgWrite), .cfgData(cfgData)
  );

  memChecker memCheck (
    .clk(clk), .reset(reset), .phase(phase),
    .fetchReq(fetchReq), .fetchAddr(fetchAddr), .instr(instr), .instrStall(instrStall),
    .memRead(memRead), .memWrite(memWrite), .dataAddr(dataAddr), .writeData(writeData),
    .byteMask(byteMask), .readData(readData), .dataStall(dataStall),
    .fetchMustStall(fetchMustStall), .fetchMustHit(fetchMustHit),
    .dataMustStall(dataMustStall), .dataMustHit(dataMustHit),
    .readErrors(readErrors), .fetchErrors(fetchErrors), .stallErrors(stallErrors),
    .checkCount(checkCount)
  );

  always #10 clk = ~clk;

  // Word-aligned address inside the window
  function automatic logic [AddrWidth-1:0] randomAddr();
    logic [7:0] word;
    word = 8'($random(seed));
    return {22'd0, word, 2'b00};
  endfunction

  // Another word of the same 16-byte line
  function automatic logic [AddrWidth-1:0] sameLine(input logic [AddrWidth-1:0] addr);
    logic [1:0] word;
    word = 2'($random(seed));
    return {addr[AddrWidth-1:4], word, 2'b00};
  endfunction

  // Called and returns on a falling edge
  task automatic fetchWord(input logic [AddrWidth-1:0] addr, input logic mustStall,
                           input logic mustHit);
    fetchReq       = 1'b1;
    fetchAddr      = addr;
    fetchMustStall = mustStall;
    fetchMustHit   = mustHit;
    // Done in the first cycle without a stall
    do begin
      @(posedge clk);
    end while (instrStall);
    @(negedge clk);
    fetchReq       = 1'b0;
    fetchMustStall = 1'b0;
    fetchMustHit   = 1'b0;
  endtask

  task automatic dataAccess(input logic write, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] wdata, input logic [3:0] mask,
                            input logic mustStall, input logic mustHit);
    memRead       = !write;
    memWrite      = write;
    dataAddr      = addr;
    writeData     = wdata;
    byteMask      = mask;
    dataMustStall = mustStall;
    dataMustHit   = mustHit;
    do begin
      @(posedge clk);
    end while (dataStall);
    @(negedge clk);
    memRead       = 1'b0;
    memWrite      = 1'b0;
    dataMustStall = 1'b0;
    dataMustHit   = 1'b0;
  endtask

  task automatic writeConfig(input logic [2:0] value);
    cfgWrite = 1'b1;
    cfgData  = value;
    @(negedge clk);
    cfgWrite = 1'b0;
    // Invalidate pulse clears the valid bits one edge later
    @(negedge clk);
    @(negedge clk);
  endtask

  task automatic printCounts();
    $display("Errors: read %0d, fetch %0d, stall %0d over %0d checks",
             readErrors, fetchErrors, stallErrors, checkCount);
  endtask

  initial begin
    logic [AddrWidth-1:0] addr;
    logic [AddrWidth-1:0] addr2;
    logic [3:0]           mask;
    seed           = 32'h8299;
    reset          = 1'b1;
    fetchReq       = 1'b0;
    fetchAddr      = '0;
    memRead        = 1'b0;
    memWrite       = 1'b0;
    dataAddr       = '0;
    writeData      = '0;
    byteMask       = 4'h0;
    cfgWrite       = 1'b0;
    cfgData        = 3'b000;
    fetchMustStall = 1'b0;
    fetchMustHit   = 1'b0;
    dataMustStall  = 1'b0;
    dataMustHit    = 1'b0;
    phase          = 3'd0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // Fill the window with caches off so every write stalls
    for (int w = 0; w < WindowWords; w++) begin
      dataAccess(1'b1, {22'd0, 8'(w), 2'b00}, $random(seed), 4'hf, 1'b1, 1'b0);
    end

    // Caches off so every access goes to the bus
    phase = 3'd1;
    for (int i = 0; i < 20; i++) begin
      fetchWord(randomAddr(), 1'b1, 1'b0);
      dataAccess(1'b0, randomAddr(), '0, 4'hf, 1'b1, 1'b0);
    end

    // Second access to a loaded line must hit
    phase = 3'd2;
    writeConfig(3'b011);
    for (int i = 0; i < 30; i++) begin
      addr = randomAddr();
      fetchWord(addr, 1'b0, 1'b0);
      fetchWord(sameLine(addr), 1'b0, 1'b1);
      addr = randomAddr();
      dataAccess(1'b0, addr, '0, 4'hf, 1'b0, 1'b0);
      dataAccess(1'b0, sameLine(addr), '0, 4'hf, 1'b0, 1'b1);
    end

    // Masked writes read back through the data cache
    phase = 3'd3;
    for (int i = 0; i < 30; i++) begin
      addr = randomAddr();
      mask = 4'($random(seed));
      dataAccess(1'b1, addr, $random(seed), mask, 1'b1, 1'b0);
      dataAccess(1'b0, addr, '0, 4'hf, 1'b0, 1'b0);
      written.push_back(addr);
    end
    // Instruction cache does not see stores
    writeConfig(3'b111);
    foreach (written[k]) begin
      fetchWord(written[k], 1'b0, 1'b0);
    end

    // First touch of each line after an invalidate must stall
    phase = 3'd4;
    writeConfig(3'b111);
    iTouched = '0;
    dTouched = '0;
    for (int i = 0; i < 15; i++) begin
      addr = randomAddr();
      fetchWord(addr, !iTouched[addr[7:4]], 1'b0);
      iTouched[addr[7:4]] = 1'b1;
      addr = randomAddr();
      dataAccess(1'b0, addr, '0, 4'hf, !dTouched[addr[7:4]], 1'b0);
      dTouched[addr[7:4]] = 1'b1;
    end

    // Both caches compete for the bus
    phase = 3'd5;
    writeConfig(3'b111);
    for (int i = 0; i < 30; i++) begin
      addr  = randomAddr();
      addr2 = randomAddr();
      fork
        fetchWord(addr, 1'b0, 1'b0);
        dataAccess(1'b0, addr2, '0, 4'hf, 1'b0, 1'b0);
      join
    end

    @(negedge clk);
    printCounts();
    if ((readErrors + fetchErrors + stallErrors == 0) && (checkCount > 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    printCounts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/memChecker.sv
`timescale 1ns/1ps
`default_nettype none

module memChecker (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [2:0]                   phase,
  input  logic                         fetchReq,
  input  logic [memPkg::AddrWidth-1:0] fetchAddr,
  input  logic [memPkg::DataWidth-1:0] instr,
  input  logic                         instrStall,
  input  logic                         memRead,
  input  logic                         memWrite,
  input  logic [memPkg::AddrWidth-1:0] dataAddr,
  input  logic [memPkg::DataWidth-1:0] writeData,
  input  logic [3:0]                   byteMask,
  input  logic [memPkg::DataWidth-1:0] readData,
  input  logic                         dataStall,
  input  logic                         fetchMustStall,
  input  logic                         fetchMustHit,
  input  logic                         dataMustStall,
  input  logic                         dataMustHit,
  output int                           readErrors,
  output int                           fetchErrors,
  output int                           stallErrors,
  output int                           checkCount
);
  import memPkg::*;

  // Reference memory, one entry per word
  logic [DataWidth-1:0] model [MemWords];
  // Stall cycles seen so far for the current access
  int fetchWait;
  int dataWait;

  function automatic string phaseName(input logic [2:0] p);
    case (p)
      3'd0: return "init";
      3'd1: return "uncached";
      3'd2: return "cached";
      3'd3: return "write";
      3'd4: return "invalidate";
      default: return "parallel";
    endcase
  endfunction

  // Byte address to word index, 1024 words
  function automatic int wordOf(input logic [AddrWidth-1:0] addr);
    return int'(addr[11:2]);
  endfunction

  task automatic checkStall(input string what, input logic [AddrWidth-1:0] addr,
                            input int waited, input logic mustStall, input logic mustHit);
    if (mustHit && waited != 0) begin
      stallErrors++;
      $display("Stall check in %s: %s of 0x%h waited %0d cycles on a loaded line",
               phaseName(phase), what, addr, waited);
    end
    if (mustStall && waited == 0) begin
      stallErrors++;
      $display("Stall check in %s: %s of 0x%h finished without the expected stall",
               phaseName(phase), what, addr);
    end
  endtask

  // Inputs settle on the falling edge, sampled here on the rising edge
  always @(posedge clk) begin
    if (reset) begin
      readErrors  = 0;
      fetchErrors = 0;
      stallErrors = 0;
      checkCount  = 0;
      fetchWait   = 0;
      dataWait    = 0;
    end else begin
      if (fetchReq && instrStall) begin
        fetchWait++;
      end else if (fetchReq) begin
        checkCount++;
        if (instr !== model[wordOf(fetchAddr)]) begin
          fetchErrors++;
          $display("** Error [%s] fetch 0x%h: expected 0x%h actual 0x%h", phaseName(phase),
                   fetchAddr, model[wordOf(fetchAddr)], instr);
        end
        checkStall("fetch", fetchAddr, fetchWait, fetchMustStall, fetchMustHit);
        fetchWait = 0;
      end

      if ((memRead || memWrite) && dataStall) begin
        dataWait++;
      end else if (memWrite) begin
        // Store is in memory now, merge only enabled bytes
        for (int b = 0; b < 4; b++) begin
          if (byteMask[b]) begin
            model[wordOf(dataAddr)][8*b +: 8] = writeData[8*b +: 8];
          end
        end
        checkStall("write", dataAddr, dataWait, dataMustStall, dataMustHit);
        dataWait = 0;
      end else if (memRead) begin
        checkCount++;
        if (readData !== model[wordOf(dataAddr)]) begin
          readErrors++;
          $display("** Error [%s] read 0x%h: expected 0x%h actual 0x%h", phaseName(phase),
                   dataAddr, model[wordOf(dataAddr)], readData);
        end
        checkStall("read", dataAddr, dataWait, dataMustStall, dataMustHit);
        dataWait = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
  input  logic                         clk,
  input  logic                         reset,
  // Fetch port
  input  logic                         fetchReq,
  input  logic [memPkg::AddrWidth-1:0] fetchAddr,
  output logic [memPkg::DataWidth-1:0] instr,
  output logic                         instrStall,
  // Data port
  input  logic                         memRead,
  input  logic                         memWrite,
  input  logic [memPkg::AddrWidth-1:0] dataAddr,
  input  logic [memPkg::DataWidth-1:0] writeData,
  input  logic [3:0]                   byteMask,
  output logic [memPkg::DataWidth-1:0] readData,
  output logic                         dataStall,
  // Configuration strobe
  input  logic                         cfgWrite,
  input  logic [2:0]                   cfgData
);
  import memPkg::*;

  logic iEnable, dEnable, invalidate;

  // Instruction cache bus master
  logic                 iBusReq, iBusReady;
  logic [AddrWidth-1:0] iBusAddr;

  // Data cache bus master
  logic                 dBusReq, dBusWrite, dBusReady;
  logic [AddrWidth-1:0] dBusAddr;
  logic [DataWidth-1:0] dBusWData;
  logic [3:0]           dBusMask;

  // Shared bus after the arbiter
  logic                 sysReq, sysWrite, sysReady;
  logic [AddrWidth-1:0] sysAddr;
  logic [DataWidth-1:0] sysWData, sysRData;
  logic [3:0]           sysMask;

  cacheControl ctrl (.clk(clk), .reset(reset), .cfgWrite(cfgWrite), .cfgData(cfgData),
                     .iEnable(iEnable), .dEnable(dEnable), .invalidate(invalidate));

  instrCache icache (.clk(clk), .reset(reset), .enable(iEnable), .invalidate(invalidate),
                     .fetchReq(fetchReq), .fetchAddr(fetchAddr), .instr(instr),
                     .instrStall(instrStall), .busReq(iBusReq), .busAddr(iBusAddr),
                     .busReady(iBusReady), .busRData(sysRData));

  dataCache dcache (.clk(clk), .reset(reset), .enable(dEnable), .invalidate(invalidate),
                    .memRead(memRead), .memWrite(memWrite), .dataAddr(dataAddr),
                    .writeData(writeData), .byteMask(byteMask), .readData(readData),
                    .dataStall(dataStall), .busReq(dBusReq), .busWrite(dBusWrite),
                    .busAddr(dBusAddr), .busWData(dBusWData), .busMask(dBusMask),
                    .busReady(dBusReady), .busRData(sysRData));

  busArbiter arb (.clk(clk), .reset(reset), .iReq(iBusReq), .iAddr(iBusAddr),
                  .dReq(dBusReq), .dWrite(dBusWrite), .dAddr(dBusAddr), .dWData(dBusWData),
                  .dMask(dBusMask), .iReady(iBusReady), .dReady(dBusReady),
                  .memReq(sysReq), .memWrite(sysWrite), .memAddr(sysAddr),
                  .memWData(sysWData), .memMask(sysMask), .memReady(sysReady));

  // Read data fans out to both caches
  busMemory mem (.clk(clk), .reset(reset), .req(sysReq), .write(sysWrite), .addr(sysAddr),
                 .wdata(sysWData), .mask(sysMask), .ready(sysReady), .rdata(sysRData));

endmodule

`default_nettype wire

//--- design/busMemory.sv
`timescale 1ns/1ps
`default_nettype none

module busMemory (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req,
  input  logic                         write,
  input  logic [memPkg::AddrWidth-1:0] addr,
  input  logic [memPkg::DataWidth-1:0] wdata,
  input  logic [3:0]                   mask,
  output logic                         ready,
  output logic [memPkg::DataWidth-1:0] rdata
);
  import memPkg::*;

  logic [DataWidth-1:0]    mem [MemWords];
  logic [LatCountBits-1:0] count;
  logic [MemIndexBits-1:0] wordIdx;
  logic                    fire;

  assign wordIdx = addr[ByteOffBits +: MemIndexBits];
  // Last wait cycle, access happens at this edge
  assign fire = req && !ready && (count == LatCountBits'(MemLatency - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      ready <= 1'b0;
    end else if (fire) begin
      count <= '0;
      ready <= 1'b1;
    end else if (req && !ready) begin
      count <= count + 1'b1;
    end else begin
      // Ready is a single-cycle pulse
      count <= '0;
      ready <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (write) begin
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) begin
            mem[wordIdx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end else begin
        rdata <= mem[wordIdx];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         iReq,
  input  logic [memPkg::AddrWidth-1:0] iAddr,
  input  logic                         dReq,
  input  logic                         dWrite,
  input  logic [memPkg::AddrWidth-1:0] dAddr,
  input  logic [memPkg::DataWidth-1:0] dWData,
  input  logic [3:0]                   dMask,
  output logic                         iReady,
  output logic                         dReady,
  output logic                         memReq,
  output logic                         memWrite,
  output logic [memPkg::AddrWidth-1:0] memAddr,
  output logic [memPkg::DataWidth-1:0] memWData,
  output logic [3:0]                   memMask,
  input  logic                         memReady
);

  // Transfer in flight and who owns it
  logic busy;
  logic ownerData;
  logic grantData;

  // Data side wins only on an idle bus
  assign grantData = busy ? ownerData : dReq;

  assign memReq   = grantData ? dReq : iReq;
  assign memWrite = grantData && dWrite;
  assign memAddr  = grantData ? dAddr : iAddr;
  // Only the data cache writes
  assign memWData = dWData;
  assign memMask  = dMask;

  // Ready goes back to the owner only
  assign dReady = memReady && grantData;
  assign iReady = memReady && !grantData;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      ownerData <= 1'b0;
    end else if (busy && memReady) begin
      busy <= 1'b0;
    end else if (!busy && memReq) begin
      // Lock the owner for the whole word
      busy      <= 1'b1;
      ownerData <= grantData;
    end
  end

endmodule

`default_nettype wire

//--- design/dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic                         invalidate,
  input  logic                         memRead,
  input  logic                         memWrite,
  input  logic [memPkg::AddrWidth-1:0] dataAddr,
  input  logic [memPkg::DataWidth-1:0] writeData,
  input  logic [3:0]                   byteMask,
  output logic [memPkg::DataWidth-1:0] readData,
  output logic                         dataStall,
  output logic                         busReq,
  output logic                         busWrite,
  output logic [memPkg::AddrWidth-1:0] busAddr,
  output logic [memPkg::DataWidth-1:0] busWData,
  output logic [3:0]                   busMask,
  input  logic                         busReady,
  input  logic [memPkg::DataWidth-1:0] busRData
);
  import memPkg::*;

  logic [TagBits-1:0]   tagArr [NumLines];
  logic [DataWidth-1:0] dataArr [NumLines*BlockWords];
  logic [NumLines-1:0]  validArr;

  cacheState            state;
  logic [TagBits-1:0]   tag;
  logic [IndexBits-1:0] index;
  logic [WordBits-1:0]  wordSel;
  logic [TagBits-1:0]   busTag;
  logic [IndexBits-1:0] busIndex;
  logic [WordBits-1:0]  busWord;
  logic                 hit;
  logic                 busLineHit;
  logic                 fillWe;
  logic                 updateWe;
  logic                 accessDone;
  logic [DataWidth-1:0] holdData;

  assign tag     = dataAddr[AddrWidth-1 -: TagBits];
  assign index   = dataAddr[ByteOffBits+WordBits +: IndexBits];
  assign wordSel = dataAddr[ByteOffBits +: WordBits];
  assign busTag   = busAddr[AddrWidth-1 -: TagBits];
  assign busIndex = busAddr[ByteOffBits+WordBits +: IndexBits];
  assign busWord  = busAddr[ByteOffBits +: WordBits];

  assign hit = (state == Idle) && enable && validArr[index] && (tagArr[index] == tag);
  // Store target already cached, enabled or not
  assign busLineHit = validArr[busIndex] && (tagArr[busIndex] == busTag);

  // Reads may hit, writes always go to the bus
  assign dataStall = (memRead || memWrite) && !(accessDone || (memRead && hit));
  assign readData  = accessDone ? holdData : dataArr[{index, wordSel}];

  assign fillWe   = (state == Refill) && busReq && busReady;
  assign updateWe = (state == WriteOut) && busReady && busLineHit;

  always_ff @(posedge clk) begin
    if (fillWe) begin
      dataArr[{busIndex, busWord}] <= busRData;
      tagArr[busIndex] <= busTag;
    end else if (updateWe) begin
      // Merge the stored bytes into the cached word
      for (int b = 0; b < 4; b++) begin
        if (busMask[b]) begin
          dataArr[{busIndex, busWord}][8*b +: 8] <= busWData[8*b +: 8];
        end
      end
    end
    if ((state == Single) && busReady) begin
      holdData <= busRData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= Idle;
      busReq     <= 1'b0;
      busWrite   <= 1'b0;
      busAddr    <= '0;
      validArr   <= '0;
      accessDone <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          if (accessDone) begin
            accessDone <= 1'b0;
          end else if (memWrite) begin
            // Write-through, no allocate on a miss
            state    <= WriteOut;
            busReq   <= 1'b1;
            busWrite <= 1'b1;
            busAddr  <= dataAddr;
            busWData <= writeData;
            busMask  <= byteMask;
          end else if (memRead && !hit) begin
            busReq   <= 1'b1;
            busWrite <= 1'b0;
            busMask  <= 4'hf;
            if (enable) begin
              state   <= Refill;
              busAddr <= {tag, index, {WordBits{1'b0}}, {ByteOffBits{1'b0}}};
              validArr[index] <= 1'b0;
            end else begin
              state   <= Single;
              busAddr <= dataAddr;
            end
          end
        end
        Refill: begin
          if (busReq && busReady) begin
            busReq <= 1'b0;
            if (&busWord) begin
              validArr[busIndex] <= 1'b1;
              state <= Idle;
            end else begin
              busAddr[ByteOffBits +: WordBits] <= busWord + 1'b1;
            end
          end else if (!busReq) begin
            busReq <= 1'b1;
          end
        end
        // Single reads and write-through share the finish
        Single, WriteOut: begin
          if (busReady) begin
            busReq     <= 1'b0;
            busWrite   <= 1'b0;
            accessDone <= 1'b1;
            state      <= Idle;
          end
        end
        default: state <= Idle;
      endcase
      if (invalidate) begin
        validArr <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/instrCache.sv
`timescale 1ns/1ps
`default_nettype none

module instrCache (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic                         invalidate,
  input  logic                         fetchReq,
  input  logic [memPkg::AddrWidth-1:0] fetchAddr,
  output logic [memPkg::DataWidth-1:0] instr,
  output logic                         instrStall,
  output logic                         busReq,
  output logic [memPkg::AddrWidth-1:0] busAddr,
  input  logic                         busReady,
  input  logic [memPkg::DataWidth-1:0] busRData
);
  import memPkg::*;

  // Line storage, one word per entry
  logic [TagBits-1:0]   tagArr [NumLines];
  logic [DataWidth-1:0] dataArr [NumLines*BlockWords];
  logic [NumLines-1:0]  validArr;

  cacheState            state;
  logic [TagBits-1:0]   tag;
  logic [IndexBits-1:0] index;
  logic [WordBits-1:0]  wordSel;
  logic [IndexBits-1:0] fillIndex;
  logic [WordBits-1:0]  fillWord;
  logic                 hit;
  logic                 fillWe;
  logic                 singleDone;
  logic [DataWidth-1:0] singleData;

  // Fetch address fields
  assign tag     = fetchAddr[AddrWidth-1 -: TagBits];
  assign index   = fetchAddr[ByteOffBits+WordBits +: IndexBits];
  assign wordSel = fetchAddr[ByteOffBits +: WordBits];
  // Refill position tracked in the bus address
  assign fillIndex = busAddr[ByteOffBits+WordBits +: IndexBits];
  assign fillWord  = busAddr[ByteOffBits +: WordBits];

  // Hits only count while idle and enabled
  assign hit = (state == Idle) && enable && validArr[index] && (tagArr[index] == tag);
  assign instrStall = fetchReq && !(hit || singleDone);
  assign instr = singleDone ? singleData : dataArr[{index, wordSel}];

  assign fillWe = (state == Refill) && busReq && busReady;

  always_ff @(posedge clk) begin
    if (fillWe) begin
      dataArr[{fillIndex, fillWord}] <= busRData;
      tagArr[fillIndex] <= busAddr[AddrWidth-1 -: TagBits];
    end
    // Uncached word held for one cycle
    if ((state == Single) && busReady) begin
      singleData <= busRData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= Idle;
      busReq     <= 1'b0;
      busAddr    <= '0;
      validArr   <= '0;
      singleDone <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          // Finished single fetch is consumed here
          if (singleDone) begin
            singleDone <= 1'b0;
          end else if (fetchReq && !hit) begin
            busReq <= 1'b1;
            if (enable) begin
              state <= Refill;
              // Start at word zero of the line
              busAddr <= {tag, index, {WordBits{1'b0}}, {ByteOffBits{1'b0}}};
              validArr[index] <= 1'b0;
            end else begin
              state   <= Single;
              busAddr <= fetchAddr;
            end
          end
        end
        Refill: begin
          if (busReq && busReady) begin
            // Drop request for one cycle between words
            busReq <= 1'b0;
            if (&fillWord) begin
              validArr[fillIndex] <= 1'b1;
              state <= Idle;
            end else begin
              busAddr[ByteOffBits +: WordBits] <= fillWord + 1'b1;
            end
          end else if (!busReq) begin
            busReq <= 1'b1;
          end
        end
        Single: begin
          if (busReady) begin
            busReq     <= 1'b0;
            singleDone <= 1'b1;
            state      <= Idle;
          end
        end
        default: state <= Idle;
      endcase
      // Invalidate wins over a fill finishing
      if (invalidate) begin
        validArr <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/cacheControl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheControl (
  input  logic       clk,
  input  logic       reset,
  input  logic       cfgWrite,
  input  logic [2:0] cfgData,
  output logic       iEnable,
  output logic       dEnable,
  output logic       invalidate
);

  // Enables are sticky, invalidate lasts one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      iEnable    <= 1'b0;
      dEnable    <= 1'b0;
      invalidate <= 1'b0;
    end else begin
      // Pulse follows the strobe by one cycle
      invalidate <= cfgWrite && cfgData[2];
      if (cfgWrite) begin
        // Bit 0 for fetches
        iEnable <= cfgData[0];
        // Bit 1 for loads and stores
        dEnable <= cfgData[1];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/memPkg.sv
`default_nettype none

package memPkg;

  // Cache geometry, shared by both caches
  localparam int BlockWords = 4;
  localparam int NumLines = 16;

  // Backing memory
  localparam int MemWords = 1024;
  // Cycles from first request to ready
  localparam int MemLatency = 2;

  // Bus widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  // Address split: tag | index | word | byte
  localparam int ByteOffBits = 2;
  localparam int WordBits = $clog2(BlockWords);
  localparam int IndexBits = $clog2(NumLines);
  localparam int TagBits = AddrWidth - IndexBits - WordBits - ByteOffBits;

  // Word index into the memory array
  localparam int MemIndexBits = $clog2(MemWords);
  // Latency counter width
  localparam int LatCountBits = $clog2(MemLatency + 1);

  // Cache controller states
  // WriteOut is only reached by the data cache
  typedef enum logic [1:0] {
    Idle,
    Refill,
    Single,
    WriteOut
  } cacheState;

endpackage

`default_nettype wire
